// ==== hw/copro_pkg.sv ====
// shared widths, lane layout, pulse lengths and types for the multiplier coprocessor
`default_nettype none

package copro_pkg;

  // ==================================================
  // datapath
  // ==================================================
  localparam int unsigned word_w      = 64;  // host fifo word in both directions
  localparam int unsigned operand_w   = 16;  // one operand and one truncated product
  localparam int unsigned num_lanes   = 2;   // lanes run in lockstep on one word
  localparam int unsigned lane_slot_w = 32;  // bit stride between lane slots

  // operand reg, product reg, result reg
  localparam int unsigned lane_stages = 3;

  // ==================================================
  // status counter and reset requests
  // ==================================================
  localparam int unsigned counter_w   = 32;
  localparam int unsigned led_w       = 10;  // top counter bits shown on the leds
  localparam int unsigned reset_req_w = 3;   // bit 0 cold, bit 1 warm, bit 2 debug

  // pulse lengths in clock cycles
  localparam int unsigned cold_ext  = 6;
  localparam int unsigned warm_ext  = 2;
  localparam int unsigned debug_ext = 32;

  // ==================================================
  // shared types
  // ==================================================
  typedef logic [word_w-1:0]    word_t;     // operand word in, result word out
  typedef logic [operand_w-1:0] operand_t;  // one 16 bit operand or product

endpackage

`default_nettype wire

// ==== hw/lane_if.sv ====
// multiplier lane link carrying operands and stall out and the truncated product back
`timescale 1ns/1ps
`default_nettype none

interface lane_if;

  // control side drives these
  logic                in_valid;  // operand pair valid this cycle
  copro_pkg::operand_t a;
  copro_pkg::operand_t b;
  logic                stall;     // freezes every lane stage

  // lane side drives these
  copro_pkg::operand_t q;         // low half of a*b
  logic                q_valid;

  modport ctrl (output in_valid, output a, output b, output stall,
                input q, input q_valid);

  modport lane (input in_valid, input a, input b, input stall,
                output q, output q_valid);

endinterface

`default_nettype wire

// ==== hw/mult_lane.sv ====
// one 16x16 multiplier lane with a three stage pipeline that freezes on stall
`timescale 1ns/1ps
`default_nettype none

module mult_lane (
  input logic  CLOCK_95,
  input logic  hps_fpga_reset_n,
  lane_if.lane lane
);

  logic [copro_pkg::lane_stages-1:0] vld;  // one valid bit per stage
  logic                              adv;  // pipeline may move this cycle
  copro_pkg::operand_t               a_r;
  copro_pkg::operand_t               b_r;
  copro_pkg::operand_t               prod_r;
  copro_pkg::operand_t               q_r;

  assign adv = !lane.stall;

  // ==================================================
  // valid chain
  // ==================================================
  always_ff @(posedge CLOCK_95 or negedge hps_fpga_reset_n) begin
    if (!hps_fpga_reset_n) begin
      vld <= '0;
    end else if (adv) begin
      vld <= {vld[copro_pkg::lane_stages-2:0], lane.in_valid};  // bubbles shift too
    end
  end

  // ==================================================
  // payload stages
  // ==================================================
  // stage 1 operand capture
  always_ff @(posedge CLOCK_95) begin
    if (adv && lane.in_valid) begin
      a_r <= lane.a;
      b_r <= lane.b;
    end
  end

  // stage 2 multiply
  always_ff @(posedge CLOCK_95) begin
    if (adv && vld[0]) begin
      prod_r <= a_r * b_r;  // 16 bit context keeps only the low half
    end
  end

  // stage 3 result register
  always_ff @(posedge CLOCK_95) begin
    if (adv && vld[1]) begin
      q_r <= prod_r;
    end
  end

  assign lane.q       = q_r;
  assign lane.q_valid = vld[copro_pkg::lane_stages-1];  // held while stalled

endmodule

`default_nettype wire

// ==== hw/mult_copro.sv ====
// multiplier coprocessor that splits operand words over two lanes and packs the products
`timescale 1ns/1ps
`default_nettype none

module mult_copro (
  input  logic             CLOCK_95,
  input  logic             hps_fpga_reset_n,
  input  copro_pkg::word_t in_readdata,
  input  logic             in_waitrequest,
  output logic             in_read,
  input  logic             out_waitrequest,
  output logic             out_write,
  output copro_pkg::word_t out_writedata
);

  // ==================================================
  // input handshake
  // ==================================================
  // take a word only when the fifo has one and the result side is free
  assign in_read = !in_waitrequest && !out_waitrequest;

  // ==================================================
  // lanes
  // ==================================================
  for (genvar i = 0; i < copro_pkg::num_lanes; i++) begin : g_lane

    lane_if lif ();

    assign lif.in_valid = in_read;
    assign lif.stall    = out_waitrequest;  // whole datapath freezes together

    // operand a in the low half of the slot, b right above it
    assign lif.a = in_readdata[i*copro_pkg::lane_slot_w +: copro_pkg::operand_w];
    assign lif.b = in_readdata[i*copro_pkg::lane_slot_w + copro_pkg::operand_w
                               +: copro_pkg::operand_w];

    mult_lane u_lane (
      .CLOCK_95         (CLOCK_95),
      .hps_fpga_reset_n (hps_fpga_reset_n),
      .lane             (lif)
    );

    // product in the slot bottom, rest of the slot zero
    assign out_writedata[i*copro_pkg::lane_slot_w +: copro_pkg::lane_slot_w] =
      {{(copro_pkg::lane_slot_w - copro_pkg::operand_w){1'b0}}, lif.q};

    // lanes move in lockstep so lane 0 speaks for all of them
    if (i == 0) begin : g_head
      assign out_write = lif.q_valid;
    end

  end

endmodule

`default_nettype wire

// ==== hw/reset_pulse_gen.sv ====
// rising edge detector that stretches each accepted request into a fixed length pulse
`timescale 1ns/1ps
`default_nettype none

module reset_pulse_gen #(
  parameter int unsigned PULSE_EXT = 6  // pulse length in cycles
) (
  input  logic CLOCK_95,
  input  logic hps_fpga_reset_n,
  input  logic req,
  output logic pulse
);

  typedef logic [$clog2(PULSE_EXT+1)-1:0] cnt_t;

  logic req_d;  // previous request sample
  logic rise;
  cnt_t cnt;    // cycles left after the current one

  assign rise = req && !req_d;

  always_ff @(posedge CLOCK_95 or negedge hps_fpga_reset_n) begin
    if (!hps_fpga_reset_n) begin
      req_d <= 1'b0;
      pulse <= 1'b0;
      cnt   <= '0;
    end else begin
      req_d <= req;
      if (!pulse) begin
        if (rise) begin  // edges seen while busy are dropped
          pulse <= 1'b1;
          cnt   <= cnt_t'(PULSE_EXT - 1);
        end
      end else if (cnt != '0) begin
        cnt <= cnt - 1'b1;
      end else begin
        pulse <= 1'b0;  // last cycle done
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/copro_top.sv ====
// coprocessor slice top with the multiplier, reset request pulses and status counter
`timescale 1ns/1ps
`default_nettype none

module copro_top (
  input  logic                              CLOCK_95,
  input  logic                              hps_fpga_reset_n,

  // host fifo to coprocessor
  input  copro_pkg::word_t                  in_readdata,
  input  logic                              in_waitrequest,
  output logic                              in_read,

  // coprocessor to host fifo
  input  logic                              out_waitrequest,
  output logic                              out_write,
  output copro_pkg::word_t                  out_writedata,

  // reset requests and the stretched pulses
  input  logic [copro_pkg::reset_req_w-1:0] reset_req,
  output logic                              cold_reset,
  output logic                              warm_reset,
  output logic                              debug_reset,

  // free running status
  output logic [copro_pkg::counter_w-1:0]   status,
  output logic [copro_pkg::led_w-1:0]       ledr
);

  // ==================================================
  // multiplier coprocessor
  // ==================================================
  mult_copro u_copro (
    .CLOCK_95         (CLOCK_95),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .in_readdata      (in_readdata),
    .in_waitrequest   (in_waitrequest),
    .in_read          (in_read),
    .out_waitrequest  (out_waitrequest),
    .out_write        (out_write),
    .out_writedata    (out_writedata)
  );

  // ==================================================
  // reset request stretchers
  // ==================================================
  reset_pulse_gen #(.PULSE_EXT(copro_pkg::cold_ext)) u_pulse_cold (
    .CLOCK_95         (CLOCK_95),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (reset_req[0]),  // cold
    .pulse            (cold_reset)
  );

  reset_pulse_gen #(.PULSE_EXT(copro_pkg::warm_ext)) u_pulse_warm (
    .CLOCK_95         (CLOCK_95),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (reset_req[1]),  // warm
    .pulse            (warm_reset)
  );

  reset_pulse_gen #(.PULSE_EXT(copro_pkg::debug_ext)) u_pulse_debug (
    .CLOCK_95         (CLOCK_95),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (reset_req[2]),  // debug
    .pulse            (debug_reset)
  );

  // ==================================================
  // status counter
  // ==================================================
  always_ff @(posedge CLOCK_95 or negedge hps_fpga_reset_n) begin
    if (!hps_fpga_reset_n) begin
      status <= '0;
    end else begin
      status <= status + 1'b1;  // wraps freely
    end
  end

  // slow top bits so the leds visibly count
  assign ledr = status[copro_pkg::counter_w-1 -: copro_pkg::led_w];

endmodule

`default_nettype wire

// ==== testbench/copro_assert.sv ====
// bound checker for the coprocessor slice with a result model and handshake, pulse and counter checks
`timescale 1ns/1ps
`default_nettype none

module copro_assert (
  input logic                              CLOCK_95,
  input logic                              hps_fpga_reset_n,
  input copro_pkg::word_t                  in_readdata,
  input logic                              in_read,
  input logic                              out_waitrequest,
  input logic                              out_write,
  input copro_pkg::word_t                  out_writedata,
  input logic [copro_pkg::reset_req_w-1:0] reset_req,
  input logic                              cold_reset,
  input logic                              warm_reset,
  input logic                              debug_reset,
  input logic [copro_pkg::counter_w-1:0]   status,
  input logic [copro_pkg::led_w-1:0]       ledr
);

  int               fail_count = 0;  // polled by the testbench
  copro_pkg::word_t model_mem [8];   // expected words in flight, three at most
  logic [2:0]       wr_ptr;
  logic [2:0]       rd_ptr;
  copro_pkg::word_t exp_head;        // oldest expected word
  logic [2:0]       pulses;          // debug, warm, cold

  task automatic count_failure(input string msg);
    fail_count++;
    $error("ERROR t=%0t %s", $time, msg);
  endtask

  // low product half per lane in its slot, zeros elsewhere
  function automatic copro_pkg::word_t expect_word(input copro_pkg::word_t w);
    copro_pkg::word_t    r;
    copro_pkg::operand_t a;
    copro_pkg::operand_t b;
    logic [31:0]         prod;
    r = '0;
    for (int i = 0; i < copro_pkg::num_lanes; i++) begin
      a    = w[i*copro_pkg::lane_slot_w +: copro_pkg::operand_w];
      b    = w[i*copro_pkg::lane_slot_w + copro_pkg::operand_w +: copro_pkg::operand_w];
      prod = 32'(a) * 32'(b);  // full product, truncated below
      r[i*copro_pkg::lane_slot_w +: copro_pkg::operand_w] = prod[copro_pkg::operand_w-1:0];
    end
    return r;
  endfunction

  // ==================================================
  // result model
  // ==================================================
  always_ff @(posedge CLOCK_95 or negedge hps_fpga_reset_n) begin
    if (!hps_fpga_reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (in_read) begin
        model_mem[wr_ptr] <= expect_word(in_readdata);
        wr_ptr            <= wr_ptr + 3'd1;
      end
      if (out_write && !out_waitrequest)
        rd_ptr <= rd_ptr + 3'd1;  // host took one
    end
  end

  assign exp_head = model_mem[rd_ptr];
  assign pulses   = {debug_reset, warm_reset, cold_reset};

  a_result: assert property (@(posedge CLOCK_95) disable iff (!hps_fpga_reset_n)
    out_write && !out_waitrequest |-> wr_ptr != rd_ptr && out_writedata == exp_head)
    else count_failure("result word differs from a*b model");
  a_stall_read: assert property (@(posedge CLOCK_95) disable iff (!hps_fpga_reset_n)
    out_waitrequest |-> !in_read)
    else count_failure("word read while result side waits");
  a_stall_hold: assert property (@(posedge CLOCK_95) disable iff (!hps_fpga_reset_n)
    out_waitrequest |=> $stable(out_write) && $stable(out_writedata))
    else count_failure("result moved while result side waits");
  a_latency: assert property (@(posedge CLOCK_95) disable iff (!hps_fpga_reset_n)
    in_read ##1 !out_waitrequest ##1 !out_waitrequest |=> out_write)
    else count_failure("result not written three cycles after read");

  // ==================================================
  // reset, counter and leds
  // ==================================================
  a_in_reset: assert property (@(posedge CLOCK_95)
    !hps_fpga_reset_n |-> !in_read && !out_write && pulses == '0 && status == '0)
    else count_failure("outputs active during reset");
  a_after_reset: assert property (@(posedge CLOCK_95)
    $rose(hps_fpga_reset_n) |-> !in_read && !out_write && pulses == '0 && status == '0)
    else count_failure("outputs active right after reset");
  a_count: assert property (@(posedge CLOCK_95) disable iff (!hps_fpga_reset_n)
    $past(hps_fpga_reset_n) |-> status == $past(status) + 32'd1)
    else count_failure("status counter skipped");
  a_leds: assert property (@(posedge CLOCK_95)
    ledr == status[copro_pkg::counter_w-1 -: copro_pkg::led_w])
    else count_failure("leds differ from top status bits");

  // ==================================================
  // reset pulse stretchers
  // ==================================================
  for (genvar i = 0; i < copro_pkg::reset_req_w; i++) begin : g_pulse
    localparam int unsigned ext = (i == 0) ? copro_pkg::cold_ext :
                                  (i == 1) ? copro_pkg::warm_ext : copro_pkg::debug_ext;
    int unsigned run_len;  // high samples so far

    always_ff @(posedge CLOCK_95 or negedge hps_fpga_reset_n) begin
      if (!hps_fpga_reset_n) begin
        run_len <= 0;
      end else begin
        run_len <= pulses[i] ? run_len + 1 : 0;
      end
    end

    a_start: assert property (@(posedge CLOCK_95) disable iff (!hps_fpga_reset_n)
      $rose(reset_req[i]) && !pulses[i] |=> pulses[i])
      else count_failure("reset pulse did not start on request");
    a_len: assert property (@(posedge CLOCK_95) disable iff (!hps_fpga_reset_n)
      $fell(pulses[i]) |-> run_len == ext)
      else count_failure("reset pulse has wrong length");
  end

endmodule

`default_nettype wire

// ==== testbench/tb_top.sv ====
// testbench for the coprocessor slice covering traffic, back-pressure, reset pulses and counter
`timescale 1ns/1ps
`default_nettype none

module tb_top;

  // ==================================================
  // run lengths
  // ==================================================
  localparam int half_period   = 10;   // 20 ns clock
  localparam int reset_cycles  = 8;
  localparam int stream_cycles = 200;  // result side never waits
  localparam int random_cycles = 300;  // both sides wait at random
  localparam int drain_limit   = 16;
  localparam int pulse_limit   = 80;   // longest pulse plus slack
  localparam int run_cycles    = reset_cycles + 4 + stream_cycles + random_cycles
                                 + 2 * drain_limit + 3 * pulse_limit + 200;

  logic                              CLOCK_95 = 1'b0;
  logic                              hps_fpga_reset_n;
  copro_pkg::word_t                  in_readdata;
  logic                              in_waitrequest;
  logic                              in_read;
  logic                              out_waitrequest;
  logic                              out_write;
  copro_pkg::word_t                  out_writedata;
  logic [copro_pkg::reset_req_w-1:0] reset_req;
  logic                              cold_reset;
  logic                              warm_reset;
  logic                              debug_reset;
  logic [copro_pkg::counter_w-1:0]   status;
  logic [copro_pkg::led_w-1:0]       ledr;

  integer seed         = 32'hff86_bf38;
  int     n_read       = 0;  // words the dut consumed
  int     n_taken      = 0;  // results the host accepted
  int     tb_errors    = 0;
  int     err_mark     = 0;  // error total when the running test began
  int     tests_run    = 0;
  int     tests_failed = 0;

  copro_top dut0 (.*);

  bind copro_top copro_assert u_chk (.*);

  always #half_period CLOCK_95 = ~CLOCK_95;

  // handshake bookkeeping for the drain check
  always @(posedge CLOCK_95) begin
    if (hps_fpga_reset_n) begin
      if (in_read)
        n_read++;
      if (out_write && !out_waitrequest)
        n_taken++;
    end
  end

  function automatic int total_errors();
    return dut0.u_chk.fail_count + tb_errors;
  endfunction

  task automatic report_test(input string name);
    int n;
    n = total_errors() - err_mark;
    tests_run++;
    if (n != 0)
      tests_failed++;
    $display("test %s: %s, %0d errors", name, (n == 0) ? "passed" : "failed", n);
    err_mark = total_errors();
  endtask

  task automatic drive_traffic(input int cycles, input bit back_pressure);
    repeat (cycles) begin
      @(negedge CLOCK_95);
      in_readdata     = {$random(seed), $random(seed)};
      in_waitrequest  = ($random(seed) & 3) == 0;  // fifo empty about a quarter of the time
      out_waitrequest = back_pressure && (($random(seed) & 3) == 0);
    end
  endtask

  // stop reading and let every word in flight come out
  task automatic drain_pipeline();
    int waited;
    @(negedge CLOCK_95);
    in_waitrequest  = 1'b1;
    out_waitrequest = 1'b0;
    waited = 0;
    while (n_taken != n_read && waited < drain_limit) begin
      @(negedge CLOCK_95);
      waited++;
    end
    if (n_taken != n_read) begin
      tb_errors++;
      $display("ERROR %0t: %0d results taken for %0d words read", $time, n_taken, n_read);
    end
  endtask

  task automatic raise_request(input int idx);
    @(negedge CLOCK_95);
    reset_req[idx] = 1'b1;
    @(negedge CLOCK_95);
    reset_req[idx] = 1'b0;
  endtask

  task automatic wait_pulses_idle();
    int waited;
    waited = 0;
    while ((cold_reset || warm_reset || debug_reset) && waited < pulse_limit) begin
      @(negedge CLOCK_95);
      waited++;
    end
    if (cold_reset || warm_reset || debug_reset) begin
      tb_errors++;
      $display("reset pulses still high after %0d cycles", pulse_limit);
    end
    repeat (2) @(negedge CLOCK_95);  // length check fires on the edge after the fall
  endtask

  // ==================================================
  // test sequence
  // ==================================================
  initial begin
    hps_fpga_reset_n = 1'b0;
    in_readdata      = '0;
    in_waitrequest   = 1'b1;  // fifo empty through reset
    out_waitrequest  = 1'b0;
    reset_req        = '0;
    repeat (reset_cycles) @(negedge CLOCK_95);
    hps_fpga_reset_n = 1'b1;
    repeat (4) @(negedge CLOCK_95);
    report_test("reset");

    drive_traffic(stream_cycles, 1'b0);
    drain_pipeline();
    report_test("stream");

    drive_traffic(random_cycles, 1'b1);
    drain_pipeline();
    report_test("back_pressure");

    raise_request(0);  // cold
    raise_request(0);  // lands inside the cold pulse
    raise_request(1);  // warm
    wait_pulses_idle();
    raise_request(2);  // debug
    repeat (8) @(negedge CLOCK_95);
    raise_request(2);  // ignored, pulse still busy
    wait_pulses_idle();
    report_test("reset_pulses");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors());
    if (tests_failed == 0 && total_errors() == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

  // watchdog
  initial begin
    #(run_cycles * 2 * half_period);
    $display("timeout after %0d cycles, run did not finish", run_cycles);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
hw/copro_pkg.sv
hw/lane_if.sv
hw/mult_lane.sv
hw/mult_copro.sv
hw/reset_pulse_gen.sv
hw/copro_top.sv
testbench/copro_assert.sv
testbench/tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with verilator, run it, and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_top -f vlog.f -Mdir obj_dir

# keep running past assertion errors so the testbench prints its verdict
out="$(./obj_dir/Vtb_top +verilator+error+limit+10000 2>&1)" || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'PASS: all tests'; then
  exit 0
fi
exit 1
